// ==== rv_load_fmt.sv ====
`timescale 1ns/1ps

module rv_load_fmt
  import rv_mem_pkg::*;
(
  input  word_t        rdata_i,
  input  logic [1:0]   addr_lo_i,
  input  ldst_funct3_e funct3_i,
  output word_t        data_o
);

  // Read word with lane views
  mem_word_u   rword;
  // Addressed byte and halfword
  logic [7:0]  sel_byte;
  logic [15:0] sel_half;

  // ========================================================================
  // Lane selection
  // ========================================================================

  assign rword = rdata_i;

  // Byte lane straight from the low address bits
  assign sel_byte = rword.lane[addr_lo_i];

  // Halfword lane from address bit 1
  // Bit 0 is zero for any access that gets this far
  assign sel_half = rword.half[addr_lo_i[1]];

  // ========================================================================
  // Sign and zero extension
  // ========================================================================

  always_comb begin
    case (funct3_i)
      LS_B: begin
        data_o = word_t'($signed(sel_byte));
      end
      LS_H: begin
        data_o = word_t'($signed(sel_half));
      end
      LS_BU: begin
        data_o = word_t'(sel_byte);
      end
      LS_HU: begin
        data_o = word_t'(sel_half);
      end
      default: begin
        // Word load, whole word returned
        data_o = rdata_i;
      end
    endcase
  end

endmodule

// ==== rv_mem_access.sv ====
`timescale 1ns/1ps

module rv_mem_access
  import rv_mem_pkg::*;
(
  input  logic         accept_i,
  input  logic         mem_read_i,
  input  logic         mem_write_i,
  input  logic         reg_write_i,
  input  ldst_funct3_e funct3_i,
  input  word_t        alu_result_i,
  input  logic         trap_i,
  input  trap_code_e   trap_code_i,
  output logic         dmem_ren_o,
  output logic         dmem_we_o,
  output word_t        dmem_addr_o,
  input  strb_t        store_strb_i,
  output strb_t        dmem_wstrb_o,
  output logic         reg_write_o,
  output logic         trap_o,
  output trap_code_e   trap_code_o
);

  // Instruction touches data memory
  logic is_mem;
  // Per-size alignment faults
  logic half_misalign;
  logic word_misalign;
  logic misalign;

  // ========================================================================
  // Misalignment check
  // ========================================================================

  assign is_mem        = mem_read_i || mem_write_i;
  assign half_misalign = alu_result_i[0];
  assign word_misalign = |alu_result_i[1:0];

  always_comb begin
    misalign = 1'b0;
    if (is_mem) begin
      case (funct3_i[1:0])
        2'b01:   misalign = half_misalign;
        2'b10:   misalign = word_misalign;
        // Byte accesses are always aligned
        default: misalign = 1'b0;
      endcase
    end
  end

  // ========================================================================
  // Trap merge
  // ========================================================================

  assign trap_o      = trap_i || misalign;
  // Misalignment wins over an incoming cause
  assign trap_code_o = misalign ? TRAP_LDST_MISALIGN : trap_code_i;

  // Trapped instructions never write the register file
  assign reg_write_o = reg_write_i && !trap_o;

  // ========================================================================
  // Data memory request
  // ========================================================================

  // One pulse in the accept cycle only
  assign dmem_ren_o = accept_i && mem_read_i && !trap_o;
  assign dmem_we_o  = accept_i && mem_write_i && !trap_o;

  // Word address, byte offset handled by the lane logic
  assign dmem_addr_o = {alu_result_i[$bits(word_t)-1:2], 2'b00};

  // Strobes only with a real write
  assign dmem_wstrb_o = dmem_we_o ? store_strb_i : '0;

endmodule

// ==== rv_mem_pkg.sv ====
`include "rv_mem_stage_settings.svh"

package rv_mem_pkg;

  // ========================================================================
  // Basic words
  // ========================================================================

  typedef logic [`RV_XLEN-1:0] word_t;
  typedef logic [`RV_STRB_W-1:0] strb_t;
  typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t;

  // Load/store size and sign, straight from funct3
  typedef enum logic [2:0] {
    LS_B  = 3'd0,
    LS_H  = 3'd1,
    LS_W  = 3'd2,
    LS_BU = 3'd4,
    LS_HU = 3'd5
  } ldst_funct3_e;

  // Source of the forwarded stage result
  typedef enum logic [2:0] {
    RES_ALU = 3'd0,
    RES_M   = 3'd2,
    RES_PC4 = 3'd3,
    RES_TGT = 3'd4
  } res_src_e;

  // Trap causes seen by the write-back stage
  typedef enum logic [`RV_TRAP_CODE_W-1:0] {
    TRAP_NONE          = 2'd0,
    TRAP_ILLEGAL       = 2'd1,
    TRAP_LDST_MISALIGN = 2'd2,
    TRAP_ECALL         = 2'd3
  } trap_code_e;

  // ========================================================================
  // Memory word, seen as byte lanes or as halfword lanes
  // ========================================================================

  typedef union packed {
    logic [`RV_STRB_W-1:0][7:0]      lane;
    logic [`RV_XLEN/16-1:0][15:0]    half;
  } mem_word_u;

endpackage

// ==== rv_mem_stage.f ====
+incdir+.
rv_mem_pkg.sv
rv_store_fmt.sv
rv_load_fmt.sv
rv_mem_access.sv
rv_mem_wb_reg.sv
rv_mem_stage.sv
rv_mem_stage_sva.sv
rv_mem_stage_tb.sv

// ==== rv_mem_stage.sv ====
`timescale 1ns/1ps

module rv_mem_stage
  import rv_mem_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  // Execute stage handshake
  input  logic         s_valid_i,
  output logic         s_ready_o,
  // Execute stage fields
  input  logic         reg_write_i,
  input  logic         mem_read_i,
  input  logic         mem_write_i,
  input  res_src_e     res_src_i,
  input  reg_addr_t    rd_i,
  input  ldst_funct3_e funct3_i,
  input  word_t        alu_result_i,
  input  word_t        rs2_data_i,
  input  word_t        pc_plus4_i,
  input  word_t        jb_target_i,
  input  word_t        m_result_i,
  input  logic         trap_i,
  input  trap_code_e   trap_code_i,
  // Data memory, combinational read
  output logic         dmem_ren_o,
  output logic         dmem_we_o,
  output word_t        dmem_addr_o,
  output word_t        dmem_wdata_o,
  output strb_t        dmem_wstrb_o,
  input  word_t        dmem_rdata_i,
  // Write-back handshake
  output logic         m_valid_o,
  input  logic         m_ready_i,
  // Write-back fields
  output logic         reg_write_wb_o,
  output logic         trap_wb_o,
  output trap_code_e   trap_code_wb_o,
  output reg_addr_t    rd_wb_o,
  output res_src_e     res_src_wb_o,
  output word_t        result_wb_o,
  output word_t        ld_data_wb_o,
  // Forwarding to earlier stages
  output word_t        result_mem_o,
  output word_t        load_data_mem_o
);

  logic       accept;
  strb_t      st_strb;
  logic       reg_write_mem;
  logic       trap_mem;
  trap_code_e trap_code_mem;

  // Instruction taken from execute this cycle
  assign accept = s_valid_i && s_ready_o;

  // ========================================================================
  // Store and load formatting
  // ========================================================================

  rv_store_fmt i_store_fmt (
    .store_data_i (rs2_data_i),
    .addr_lo_i    (alu_result_i[1:0]),
    .funct3_i     (funct3_i),
    .wdata_o      (dmem_wdata_o),
    .wstrb_o      (st_strb)
  );

  rv_load_fmt i_load_fmt (
    .rdata_i   (dmem_rdata_i),
    .addr_lo_i (alu_result_i[1:0]),
    .funct3_i  (funct3_i),
    .data_o    (load_data_mem_o)
  );

  // ========================================================================
  // Alignment, traps and memory request
  // ========================================================================

  rv_mem_access i_mem_access (
    .accept_i     (accept),
    .mem_read_i   (mem_read_i),
    .mem_write_i  (mem_write_i),
    .reg_write_i  (reg_write_i),
    .funct3_i     (funct3_i),
    .alu_result_i (alu_result_i),
    .trap_i       (trap_i),
    .trap_code_i  (trap_code_i),
    .dmem_ren_o   (dmem_ren_o),
    .dmem_we_o    (dmem_we_o),
    .dmem_addr_o  (dmem_addr_o),
    .store_strb_i (st_strb),
    .dmem_wstrb_o (dmem_wstrb_o),
    .reg_write_o  (reg_write_mem),
    .trap_o       (trap_mem),
    .trap_code_o  (trap_code_mem)
  );

  // ========================================================================
  // Forwarded result select
  // ========================================================================

  always_comb begin
    case (res_src_i)
      RES_M:   result_mem_o = m_result_i;
      RES_PC4: result_mem_o = pc_plus4_i;
      RES_TGT: result_mem_o = jb_target_i;
      // ALU result for everything else
      default: result_mem_o = alu_result_i;
    endcase
  end

  // ========================================================================
  // MEM/WB register
  // ========================================================================

  rv_mem_wb_reg i_mem_wb_reg (
    .clk         (clk),
    .rst_n       (rst_n),
    .s_valid_i   (s_valid_i),
    .s_ready_o   (s_ready_o),
    .m_valid_o   (m_valid_o),
    .m_ready_i   (m_ready_i),
    .reg_write_i (reg_write_mem),
    .trap_i      (trap_mem),
    .trap_code_i (trap_code_mem),
    .rd_i        (rd_i),
    .res_src_i   (res_src_i),
    .result_i    (result_mem_o),
    .ld_data_i   (load_data_mem_o),
    .reg_write_o (reg_write_wb_o),
    .trap_o      (trap_wb_o),
    .trap_code_o (trap_code_wb_o),
    .rd_o        (rd_wb_o),
    .res_src_o   (res_src_wb_o),
    .result_o    (result_wb_o),
    .ld_data_o   (ld_data_wb_o)
  );

endmodule

// ==== rv_mem_stage_cases.txt ====
# name rd mw rw f3 rs addr rs2 trap tcode init stall(dec) burst
#   then expected: load result strobe trap_code memory_word_after
lb_0     1 0 1 0 0 00000100 00000000 0 0 81f27e93 0 0 ffffff93 00000100 0 0 81f27e93
lb_1     1 0 1 0 0 00000101 00000000 0 0 81f27e93 0 0 0000007e 00000101 0 0 81f27e93
lb_2     1 0 1 0 0 00000102 00000000 0 0 81f27e93 0 0 fffffff2 00000102 0 0 81f27e93
lb_3     1 0 1 0 0 00000103 00000000 0 0 81f27e93 0 0 ffffff81 00000103 0 0 81f27e93
lbu_0    1 0 1 4 0 00000100 00000000 0 0 81f27e93 0 0 00000093 00000100 0 0 81f27e93
lbu_3    1 0 1 4 0 00000103 00000000 0 0 81f27e93 0 0 00000081 00000103 0 0 81f27e93
lh_0     1 0 1 1 0 00000104 00000000 0 0 81f27e93 0 0 00007e93 00000104 0 0 81f27e93
lh_2     1 0 1 1 0 00000106 00000000 0 0 81f27e93 0 0 ffff81f2 00000106 0 0 81f27e93
lhu_0    1 0 1 5 0 00000104 00000000 0 0 81f27e93 0 0 00007e93 00000104 0 0 81f27e93
lhu_2    1 0 1 5 0 00000106 00000000 0 0 81f27e93 0 0 000081f2 00000106 0 0 81f27e93
lw_0     1 0 1 2 0 00000108 00000000 0 0 81f27e93 0 0 81f27e93 00000108 0 0 81f27e93
sb_0     0 1 0 0 0 00000110 123456a5 0 0 11223344 0 0 00000000 00000110 1 0 112233a5
sb_1     0 1 0 0 0 00000111 123456a5 0 0 11223344 0 0 00000000 00000111 2 0 1122a544
sb_2     0 1 0 0 0 00000112 123456a5 0 0 11223344 0 0 00000000 00000112 4 0 11a53344
sb_3     0 1 0 0 0 00000113 123456a5 0 0 11223344 0 0 00000000 00000113 8 0 a5223344
sh_0     0 1 0 1 0 00000114 123456a5 0 0 11223344 0 0 00000000 00000114 3 0 112256a5
sh_2     0 1 0 1 0 00000116 123456a5 0 0 11223344 0 0 00000000 00000116 c 0 56a53344
sw_0     0 1 0 2 0 00000118 123456a5 0 0 11223344 0 0 00000000 00000118 f 0 123456a5
mis_lh   1 0 1 1 0 00000105 00000000 0 0 81f27e93 0 0 00000000 00000105 0 2 81f27e93
mis_lw   1 0 1 2 0 0000010a 00000000 0 0 81f27e93 0 0 00000000 0000010a 0 2 81f27e93
mis_sh   0 1 0 1 0 00000117 123456a5 0 0 11223344 0 0 00000000 00000117 0 2 11223344
mis_sw   0 1 0 2 0 00000119 123456a5 0 0 11223344 0 0 00000000 00000119 0 2 11223344
trap_ec  0 0 1 0 0 00000040 00000000 1 3 00000000 0 0 00000000 00000040 0 3 00000000
trap_ld  1 0 1 2 0 00000108 00000000 1 1 81f27e93 0 0 00000000 00000108 0 1 81f27e93
res_alu  0 0 1 0 0 00000abc 00000000 0 0 00000000 0 0 00000000 00000abc 0 0 00000000
res_m    0 0 1 0 2 00000abc 00000000 0 0 00000000 0 0 00000000 cafe0001 0 0 00000000
res_pc4  0 0 1 0 3 00000abc 00000000 0 0 00000000 0 0 00000000 00001004 0 0 00000000
res_tgt  0 0 1 0 4 00000abc 00000000 0 0 00000000 0 0 00000000 00002000 0 0 00000000
res_oth  0 0 1 0 7 00000abc 00000000 0 0 00000000 0 0 00000000 00000abc 0 0 00000000
hold_lw  1 0 1 2 0 0000011c 00000000 0 0 deadbeef 4 0 deadbeef 0000011c 0 0 deadbeef
hold_pc4 0 0 1 0 3 00000030 00000000 0 0 00000000 3 0 00000000 00001004 0 0 00000000
bb_lb    1 0 1 0 0 00000120 00000000 0 0 000000f0 0 1 fffffff0 00000120 0 0 000000f0
bb_lhu   1 0 1 5 0 00000124 00000000 0 0 1234beef 0 1 0000beef 00000124 0 0 1234beef
bb_sw    0 1 0 2 0 00000128 0a0b0c0d 0 0 00000000 0 1 00000000 00000128 f 0 0a0b0c0d
bb_tgt   0 0 1 0 4 0000012c 00000000 0 0 00000000 0 1 00000000 00002000 0 0 00000000
bb_mis   1 0 1 1 0 00000131 00000000 0 0 55aa55aa 0 1 00000000 00000131 0 2 55aa55aa

// ==== rv_mem_stage_settings.svh ====
`ifndef RV_MEM_STAGE_SETTINGS_SVH
`define RV_MEM_STAGE_SETTINGS_SVH

// ==========================================================================
// Memory stage widths
// ==========================================================================

// Data and address word width
`define RV_XLEN 32

// Destination register index width
`define RV_REG_ADDR_W 5

// One strobe bit per byte lane of a word
`define RV_STRB_W 4

// Trap code carried down the pipeline
`define RV_TRAP_CODE_W 2

// All widths above are tied to RV32I encodings
// and change only together with the instruction set

`endif

// ==== rv_mem_stage_sva.sv ====
`timescale 1ns/1ps

module rv_mem_stage_sva
  import rv_mem_pkg::*;
(
  input logic       clk,
  input logic       rst_n,
  input logic       s_ready_o,
  input logic       m_valid_o,
  input logic       m_ready_i,
  input logic       reg_write_wb_o,
  input logic       trap_wb_o,
  input trap_code_e trap_code_wb_o,
  input reg_addr_t  rd_wb_o,
  input res_src_e   res_src_wb_o,
  input word_t      result_wb_o,
  input word_t      ld_data_wb_o,
  input logic       dmem_ren_o,
  input logic       dmem_we_o,
  input strb_t      dmem_wstrb_o
);

  // Count of failed assertion attempts
  int fail_cnt = 0;

  // ========================================================================
  // Write-back side holds while downstream stalls
  // ========================================================================

  a_wb_hold: assert property (@(posedge clk) disable iff (!rst_n)
    m_valid_o && !m_ready_i |=> m_valid_o && $stable(result_wb_o)
      && $stable(ld_data_wb_o) && $stable(reg_write_wb_o)
      && $stable(trap_wb_o) && $stable(trap_code_wb_o)
      && $stable(rd_wb_o) && $stable(res_src_wb_o))
    else begin
      $error("write-back outputs changed under back-pressure");
      fail_cnt++;
    end

  // No request while the stage is full
  a_no_req: assert property (@(posedge clk) disable iff (!rst_n)
    !s_ready_o |-> !dmem_ren_o && !dmem_we_o)
    else begin
      $error("memory request while s_ready_o is low");
      fail_cnt++;
    end

  a_strb_idle: assert property (@(posedge clk) disable iff (!rst_n)
    !dmem_we_o |-> dmem_wstrb_o == '0)
    else begin
      $error("write strobes set without a write");
      fail_cnt++;
    end

endmodule

bind rv_mem_stage rv_mem_stage_sva i_sva (.*);

// ==== rv_mem_stage_tb.sv ====
`timescale 1ns/1ps

module rv_mem_stage_tb
  import rv_mem_pkg::*;
;

  // Column map of one case line
  localparam int C_RD = 0, C_MW = 1, C_RW = 2, C_F3 = 3, C_RS = 4, C_ADDR = 5;
  localparam int C_RS2 = 6, C_TR = 7, C_TC = 8, C_INIT = 9, C_STALL = 10, C_BB = 11;
  localparam int C_LD = 12, C_RES = 13, C_STRB = 14, C_CODE = 15, C_MEM = 16;
  localparam int TIMEOUT = 50;

  logic clk = 1'b0;
  logic rst_n;
  logic s_valid_i, s_ready_o, reg_write_i, mem_read_i, mem_write_i, trap_i;
  res_src_e res_src_i;
  reg_addr_t rd_i;
  ldst_funct3_e funct3_i;
  word_t alu_result_i, rs2_data_i, pc_plus4_i, jb_target_i, m_result_i;
  trap_code_e trap_code_i;
  logic dmem_ren_o, dmem_we_o;
  word_t dmem_addr_o, dmem_wdata_o, dmem_rdata_i;
  strb_t dmem_wstrb_o;
  logic m_valid_o, m_ready_i, reg_write_wb_o, trap_wb_o;
  trap_code_e trap_code_wb_o;
  reg_addr_t rd_wb_o;
  res_src_e res_src_wb_o;
  word_t result_wb_o, ld_data_wb_o, result_mem_o, load_data_mem_o;

  // Case table and bookkeeping
  logic [8*16-1:0] names [0:47];
  logic [31:0] fld [0:47][0:16];
  int case_err [0:47];
  int n_cases, n_tests, errors;
  integer seed = 32'hae20_332c;
  word_t mem [0:15];

  always #4 clk = ~clk;

  rv_mem_stage i_dut (.*);

  // ==========================================================================
  // Data memory model, combinational read and strobed write
  // ==========================================================================

  assign dmem_rdata_i = mem[dmem_addr_o[5:2]];

  always @(posedge clk) begin
    if (dmem_we_o) begin
      for (int b = 0; b < 4; b++) begin
        if (dmem_wstrb_o[b]) mem[dmem_addr_o[5:2]][8*b +: 8] <= dmem_wdata_o[8*b +: 8];
      end
    end
  end

  task automatic check_word(input int k, input string what, input word_t exp, input word_t act);
    if (exp !== act) begin
      $display("error %0s %s: expected %h actual %h", names[k], what, exp, act);
      case_err[k]++;
      errors++;
    end
  endtask

  task automatic check_strb(input int k, input string what, input strb_t exp, input strb_t act);
    if (exp !== act) begin
      $display("error %0s %s: expected %h actual %h", names[k], what, exp, act);
      case_err[k]++;
      errors++;
    end
  endtask

  task automatic check_trap(input int k, input string what, input trap_code_e exp,
                            input trap_code_e act);
    if (exp !== act) begin
      $display("error %0s %s: expected %0d actual %0d", names[k], what, exp, act);
      case_err[k]++;
      errors++;
    end
  endtask

  task automatic check_flag(input int k, input string what, input logic exp, input logic act);
    if (exp !== act) begin
      $display("error %0s %s: expected %b actual %b", names[k], what, exp, act);
      case_err[k]++;
      errors++;
    end
  endtask

  task automatic abort_on_timeout(input int k, input string what);
    $display("timeout in test %0s: %s never went high", names[k], what);
    $display("STATUS: FAIL");
    $finish;
  endtask

  task automatic drive_case(input int k);
    mem_read_i   <= fld[k][C_RD][0];
    mem_write_i  <= fld[k][C_MW][0];
    reg_write_i  <= fld[k][C_RW][0];
    funct3_i     <= ldst_funct3_e'(fld[k][C_F3][2:0]);
    res_src_i    <= res_src_e'(fld[k][C_RS][2:0]);
    alu_result_i <= fld[k][C_ADDR];
    rs2_data_i   <= fld[k][C_RS2];
    trap_i       <= fld[k][C_TR][0];
    trap_code_i  <= trap_code_e'(fld[k][C_TC][1:0]);
    rd_i         <= reg_addr_t'(k + 1);
    s_valid_i    <= 1'b1;
    m_ready_i    <= 1'b1;
  endtask

  // Same-cycle outputs while the case is presented
  task automatic check_comb(input int k);
    logic ok;
    ok = (fld[k][C_CODE] == 0);
    check_word(k, "result_mem_o", fld[k][C_RES], result_mem_o);
    check_strb(k, "dmem_wstrb_o", strb_t'(fld[k][C_STRB]), dmem_wstrb_o);
    check_flag(k, "dmem_ren_o", fld[k][C_RD][0] && ok, dmem_ren_o);
    check_flag(k, "dmem_we_o", fld[k][C_MW][0] && ok, dmem_we_o);
    if (fld[k][C_RD][0] && ok) check_word(k, "load_data_mem_o", fld[k][C_LD], load_data_mem_o);
  endtask

  task automatic check_wb(input int k);
    logic ok;
    ok = (fld[k][C_CODE] == 0);
    check_flag(k, "m_valid_o", 1'b1, m_valid_o);
    check_word(k, "result_wb_o", fld[k][C_RES], result_wb_o);
    // Register index wraps at the 5-bit field width
    check_word(k, "rd_wb_o", word_t'((k + 1) % 32), word_t'(rd_wb_o));
    check_word(k, "res_src_wb_o", fld[k][C_RS], word_t'(res_src_wb_o));
    check_trap(k, "trap_code_wb_o", trap_code_e'(fld[k][C_CODE][1:0]), trap_code_wb_o);
    check_flag(k, "trap_wb_o", !ok, trap_wb_o);
    check_flag(k, "reg_write_wb_o", fld[k][C_RW][0] && ok, reg_write_wb_o);
    if (fld[k][C_RD][0] && ok) check_word(k, "ld_data_wb_o", fld[k][C_LD], ld_data_wb_o);
  endtask

  task automatic report(input int k);
    check_word(k, "memory word", fld[k][C_MEM], mem[fld[k][C_ADDR][5:2]]);
    n_tests++;
    $display("test %0s %s", names[k], (case_err[k] == 0) ? "ok" : "failed");
  endtask

  // ==========================================================================
  // One case alone, with optional downstream stall
  // ==========================================================================

  task automatic run_single(input int k);
    int cnt;
    repeat ($unsigned($random(seed)) % 4) @(posedge clk);
    @(posedge clk);
    mem[fld[k][C_ADDR][5:2]] <= fld[k][C_INIT];
    drive_case(k);
    cnt = 0;
    @(negedge clk);
    while (!s_ready_o && cnt < TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (!s_ready_o) abort_on_timeout(k, "s_ready_o");
    check_comb(k);
    @(posedge clk);
    s_valid_i <= 1'b0;
    if (fld[k][C_STALL] > 0) m_ready_i <= 1'b0;
    cnt = 0;
    @(negedge clk);
    while (!m_valid_o && cnt < TIMEOUT) begin
      @(negedge clk);
      cnt++;
    end
    if (!m_valid_o) abort_on_timeout(k, "m_valid_o");
    // Result is due one clock after acceptance
    check_word(k, "extra latency", 0, word_t'(cnt));
    check_wb(k);
    for (int i = 1; i < fld[k][C_STALL]; i++) begin
      @(negedge clk);
      check_flag(k, "s_ready_o under stall", 1'b0, s_ready_o);
      // Every write-back output still shows this case
      check_wb(k);
    end
    if (fld[k][C_STALL] > 0) begin
      @(posedge clk);
      m_ready_i <= 1'b1;
    end
    report(k);
  endtask

  initial begin
    int fd;
    int nb;
    int bq [$];
    string line;
    rst_n = 1'b0;
    s_valid_i = 1'b0;
    reg_write_i = 1'b0;
    mem_read_i = 1'b0;
    mem_write_i = 1'b0;
    res_src_i = RES_ALU;
    rd_i = '0;
    funct3_i = LS_W;
    alu_result_i = '0;
    rs2_data_i = '0;
    trap_i = 1'b0;
    trap_code_i = TRAP_NONE;
    m_ready_i = 1'b1;
    // Fixed sources for the other result inputs
    pc_plus4_i = 32'h0000_1004;
    jb_target_i = 32'h0000_2000;
    m_result_i = 32'hcafe_0001;
    for (int i = 0; i < 16; i++) mem[i] = 32'h9e37_79b9 * (i + 1);
    n_cases = 0;
    n_tests = 0;
    errors = 0;
    fd = $fopen("rv_mem_stage_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open the case file");
      $display("STATUS: FAIL");
      $finish;
    end else begin
      while ($fgets(line, fd)) begin
        if (line.len() > 4 && line[0] != "#") begin
          nb = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %d %h %h %h %h %h %h",
                       names[n_cases], fld[n_cases][0], fld[n_cases][1], fld[n_cases][2],
                       fld[n_cases][3], fld[n_cases][4], fld[n_cases][5], fld[n_cases][6],
                       fld[n_cases][7], fld[n_cases][8], fld[n_cases][9], fld[n_cases][10],
                       fld[n_cases][11], fld[n_cases][12], fld[n_cases][13],
                       fld[n_cases][14], fld[n_cases][15], fld[n_cases][16]);
          if (nb != 18) begin
            $display("case file line has %0d fields instead of 18", nb);
            errors++;
          end else begin
            case_err[n_cases] = 0;
            if (fld[n_cases][C_BB][0]) bq.push_back(n_cases);
            n_cases++;
          end
        end
      end
      $fclose(fd);
    end
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    for (int k = 0; k < n_cases; k++) begin
      if (!fld[k][C_BB][0]) run_single(k);
    end
    // ==========================================================================
    // Back-to-back burst, one case per clock
    // ==========================================================================
    @(posedge clk);
    foreach (bq[j]) mem[fld[bq[j]][C_ADDR][5:2]] <= fld[bq[j]][C_INIT];
    drive_case(bq[0]);
    for (int p = 0; p < bq.size(); p++) begin
      @(negedge clk);
      check_flag(bq[p], "s_ready_o in burst", 1'b1, s_ready_o);
      check_comb(bq[p]);
      if (p > 0) check_wb(bq[p-1]);
      @(posedge clk);
      if (p < bq.size() - 1) drive_case(bq[p+1]);
      else s_valid_i <= 1'b0;
    end
    @(negedge clk);
    check_wb(bq[bq.size()-1]);
    foreach (bq[j]) report(bq[j]);
    // Handshake and request assertions count as failures too
    errors += i_dut.i_sva.fail_cnt;
    $display("tests %0d, errors %0d", n_tests, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== rv_mem_wb_reg.sv ====
`timescale 1ns/1ps

module rv_mem_wb_reg
  import rv_mem_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       s_valid_i,
  output logic       s_ready_o,
  output logic       m_valid_o,
  input  logic       m_ready_i,
  input  logic       reg_write_i,
  input  logic       trap_i,
  input  trap_code_e trap_code_i,
  input  reg_addr_t  rd_i,
  input  res_src_e   res_src_i,
  input  word_t      result_i,
  input  word_t      ld_data_i,
  output logic       reg_write_o,
  output logic       trap_o,
  output trap_code_e trap_code_o,
  output reg_addr_t  rd_o,
  output res_src_e   res_src_o,
  output word_t      result_o,
  output word_t      ld_data_o
);

  // Register empty or being drained this cycle
  logic advance;

  // ========================================================================
  // Handshake
  // ========================================================================

  assign advance   = !m_valid_o || m_ready_i;
  assign s_ready_o = advance;

  // ========================================================================
  // Control bits, cleared on a bubble
  // ========================================================================

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      m_valid_o   <= 1'b0;
      reg_write_o <= 1'b0;
      trap_o      <= 1'b0;
    end else if (advance) begin
      m_valid_o   <= s_valid_i;
      // Downstream may act on these without checking valid
      reg_write_o <= s_valid_i && reg_write_i;
      trap_o      <= s_valid_i && trap_i;
    end
  end

  // ========================================================================
  // Payload, loaded on every advance
  // ========================================================================

  always_ff @(posedge clk) begin
    if (advance) begin
      trap_code_o <= trap_code_i;
      rd_o        <= rd_i;
      res_src_o   <= res_src_i;
      result_o    <= result_i;
      // Formatted load value from the combinational read
      ld_data_o   <= ld_data_i;
    end
  end

  // Meaningful only while m_valid_o is high

endmodule

// ==== rv_store_fmt.sv ====
`timescale 1ns/1ps

module rv_store_fmt
  import rv_mem_pkg::*;
(
  input  word_t        store_data_i,
  input  logic [1:0]   addr_lo_i,
  input  ldst_funct3_e funct3_i,
  output word_t        wdata_o,
  output strb_t        wstrb_o
);

  // Outgoing word built lane by lane
  mem_word_u wword;
  // Strobe for the access size before the lane shift
  strb_t     size_strb;

  // ========================================================================
  // Data replication across byte lanes
  // ========================================================================

  always_comb begin
    wword = store_data_i;
    case (funct3_i[1:0])
      2'b00: begin
        // Byte goes to every lane, strobe picks the one written
        wword.lane[0] = store_data_i[7:0];
        wword.lane[1] = store_data_i[7:0];
        wword.lane[2] = store_data_i[7:0];
        wword.lane[3] = store_data_i[7:0];
        size_strb     = 4'b0001;
      end
      2'b01: begin
        // Halfword in both the low and the high pair of lanes
        wword.lane[0] = store_data_i[7:0];
        wword.lane[1] = store_data_i[15:8];
        wword.lane[2] = store_data_i[7:0];
        wword.lane[3] = store_data_i[15:8];
        size_strb     = 4'b0011;
      end
      default: begin
        // Full word as is
        size_strb = 4'b1111;
      end
    endcase
  end

  assign wdata_o = wword;

  // Lane mask moved up to the addressed byte
  assign wstrb_o = size_strb << addr_lo_i;

endmodule
